/* ntm_tensor_product.f */
verilog/ntm_tensor_pkg.sv
verilog/ntm_scalar_adder.sv
verilog/ntm_scalar_multiplier.sv
verilog/ntm_tensor_buffer.sv
verilog/ntm_tensor_product.sv
testbench/ntm_tensor_clock.sv
testbench/ntm_tensor_assertions.sv
testbench/ntm_tensor_product_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module ntm_tensor_product_tb \
  -f ntm_tensor_product.f \
  -Mdir obj_dir

./obj_dir/Vntm_tensor_product_tb | tee sim.log

if grep -qx '>>> PASS' sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi

/* testbench/ntm_tensor_assertions.sv */
`timescale 1ns/1ps

module ntm_tensor_assertions (
  input logic                         CLK,
  input logic                         RST,
  input logic                         ready,
  input ntm_tensor_pkg::axis_strobe_t data_out_enable,
  input ntm_tensor_pkg::ctrl_state_e  state
);

  import ntm_tensor_pkg::*;

  // Done is a single-cycle pulse
  ready_one_cycle: assert property (@(posedge CLK) disable iff (RST) ready |=> !ready)
    else $error("ready stayed high for more than one cycle");

  // Slice boundary only on a row boundary
  strobe_i_needs_j: assert property (@(posedge CLK) disable iff (RST)
    data_out_enable.i |-> data_out_enable.j)
    else $error("data_out_enable.i without data_out_enable.j");

  // Row boundary only on an element
  strobe_j_needs_k: assert property (@(posedge CLK) disable iff (RST)
    data_out_enable.j |-> data_out_enable.k)
    else $error("data_out_enable.j without data_out_enable.k");

  // Outputs are presented only in EMIT
  strobe_only_in_emit: assert property (@(posedge CLK) disable iff (RST)
    (data_out_enable != '0) |-> (state == EMIT))
    else $error("output strobe outside the EMIT state");

endmodule

bind ntm_tensor_product ntm_tensor_assertions u_assertions (
  .CLK             (CLK),
  .RST             (RST),
  .ready           (ready),
  .data_out_enable (data_out_enable),
  .state           (state)
);

/* testbench/ntm_tensor_clock.sv */
`timescale 1ns/1ps

module ntm_tensor_clock (
  output logic CLK
);

  // Half of the 4 ns period
  localparam real HALF_PERIOD = 2.0;

  // Free running from time zero, first rise at 2 ns
  initial begin
    CLK = 1'b0;
  end

  always begin
    #(HALF_PERIOD);
    CLK = ~CLK;
  end

endmodule

/* testbench/ntm_tensor_product_tb.sv */
`timescale 1ns/1ps

module ntm_tensor_product_tb;

  import ntm_tensor_pkg::*;

  ////////////////////////////////////////////////////////////
  // Run limits
  ////////////////////////////////////////////////////////////

  localparam int          NUM_CASES     = 10;
  localparam int          CLK_PERIOD_NS = 4;
  localparam int unsigned SEED          = 32'hfba3_cd1e;
  // 2 us per row plus 5000 multiplier latencies per row
  localparam longint ROW_BUDGET_NS = 2000 + 5000 * (DATA_W + 1) * CLK_PERIOD_NS;
  localparam longint WATCHDOG_NS   = NUM_CASES * ROW_BUDGET_NS + 100 * CLK_PERIOD_NS;

  typedef enum logic [1:0] {PAT_RANDOM, PAT_MAX, PAT_ZERO} pattern_e;

  // One table row
  // Gap rows also send all of B before A
  typedef struct packed {
    tensor_dims_t      size_a;
    tensor_dims_t      size_b;
    logic [DATA_W-1:0] modulus;
    pattern_e          pattern;
    logic              gap;
  } case_row_t;

  logic              CLK;
  logic              RST;
  logic              start;
  logic [DATA_W-1:0] modulo_in;
  tensor_dims_t      size_a;
  tensor_dims_t      size_b;
  logic [DATA_W-1:0] data_a_in;
  logic              data_a_enable;
  logic [DATA_W-1:0] data_b_in;
  logic              data_b_enable;
  logic              ready;
  logic [DATA_W-1:0] data_out;
  axis_strobe_t      data_out_enable;

  case_row_t         cases [NUM_CASES];
  logic [DATA_W-1:0] a_vals [MAX_DIM*MAX_DIM*MAX_DIM];
  logic [DATA_W-1:0] b_vals [MAX_DIM*MAX_DIM*MAX_DIM];
  logic [DATA_W-1:0] exp_data [$];
  axis_strobe_t      exp_strobe [$];
  axis_strobe_t      prev_enable;
  int                ready_count;
  int                mismatch_count;
  int                other_error_count;

  ntm_tensor_clock u_ntm_tensor_clock (.CLK(CLK));

  ntm_tensor_product u_ntm_tensor_product (
    .CLK             (CLK),
    .RST             (RST),
    .start           (start),
    .modulo_in       (modulo_in),
    .size_a          (size_a),
    .size_b          (size_b),
    .data_a_in       (data_a_in),
    .data_a_enable   (data_a_enable),
    .data_b_in       (data_b_in),
    .data_b_enable   (data_b_enable),
    .ready           (ready),
    .data_out        (data_out),
    .data_out_enable (data_out_enable)
  );

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      mismatch_count++;
      $display("Mismatch at %0t: %s, got 0x%0h, expected 0x%0h", $time, what, got, expected);
    end
  endtask

  // A is I x J x M and B is I x M x K
  function automatic case_row_t make_row(input int dim_i, input int dim_j, input int dim_m,
                                         input int dim_k, input int modulus,
                                         input pattern_e pattern, input logic gap);
    case_row_t row;
    row.size_a  = '{i: DIM_W'(dim_i), j: DIM_W'(dim_j), k: DIM_W'(dim_m)};
    row.size_b  = '{i: DIM_W'(dim_i), j: DIM_W'(dim_m), k: DIM_W'(dim_k)};
    row.modulus = DATA_W'(modulus);
    row.pattern = pattern;
    row.gap     = gap;
    return row;
  endfunction

  function automatic logic [DATA_W-1:0] pick_element(input case_row_t row);
    case (row.pattern)
      PAT_MAX:  return row.modulus - DATA_W'(1);
      PAT_ZERO: return '0;
      default:  return DATA_W'($urandom % 32'(row.modulus));
    endcase
  endfunction

  // Reference contraction over m in i, j, k output order
  task automatic build_expected(input case_row_t row);
    int                dim_i;
    int                dim_j;
    int                dim_m;
    int                dim_k;
    longint unsigned   acc;
    axis_strobe_t      strobe;
    dim_i = int'(row.size_a.i);
    dim_j = int'(row.size_a.j);
    dim_m = int'(row.size_a.k);
    dim_k = int'(row.size_b.k);
    for (int e = 0; e < dim_i * dim_j * dim_m; e++) begin
      a_vals[e] = pick_element(row);
    end
    for (int e = 0; e < dim_i * dim_m * dim_k; e++) begin
      b_vals[e] = pick_element(row);
    end
    for (int i = 0; i < dim_i; i++) begin
      for (int j = 0; j < dim_j; j++) begin
        for (int k = 0; k < dim_k; k++) begin
          acc = 0;
          for (int m = 0; m < dim_m; m++) begin
            acc = (acc + 64'(a_vals[(i * dim_j + j) * dim_m + m])
                       * 64'(b_vals[(i * dim_m + m) * dim_k + k])) % 64'(row.modulus);
          end
          strobe.k = 1'b1;
          strobe.j = (k == dim_k - 1);
          strobe.i = strobe.j && (j == dim_j - 1);
          exp_data.push_back(DATA_W'(acc));
          exp_strobe.push_back(strobe);
        end
      end
    end
  endtask

  // One element per strobe with gaps of 1 to 4 idle cycles
  task automatic drive_stream(input logic is_b, input int count, input logic gap);
    int idle;
    for (int e = 0; e < count; e++) begin
      @(posedge CLK);
      if (is_b) begin
        data_b_in     <= b_vals[e];
        data_b_enable <= 1'b1;
      end else begin
        data_a_in     <= a_vals[e];
        data_a_enable <= 1'b1;
      end
      if (gap) begin
        idle = int'($urandom % 4);
        @(posedge CLK);
        data_a_enable <= 1'b0;
        data_b_enable <= 1'b0;
        repeat (idle) @(posedge CLK);
      end
    end
    @(posedge CLK);
    if (is_b) data_b_enable <= 1'b0;
    else data_a_enable <= 1'b0;
  endtask

  task automatic run_case(input int index);
    case_row_t row;
    int        n_a;
    int        n_b;
    row = cases[index];
    n_a = int'(row.size_a.i) * int'(row.size_a.j) * int'(row.size_a.k);
    n_b = int'(row.size_b.i) * int'(row.size_b.j) * int'(row.size_b.k);
    build_expected(row);
    @(posedge CLK);
    start     <= 1'b1;
    modulo_in <= row.modulus;
    size_a    <= row.size_a;
    size_b    <= row.size_b;
    @(posedge CLK);
    // Modulus is sampled on the pulse so scramble it afterwards
    start     <= 1'b0;
    modulo_in <= '0;
    if (row.gap) begin
      drive_stream(1'b1, n_b, 1'b1);
      drive_stream(1'b0, n_a, 1'b1);
    end else begin
      fork
        drive_stream(1'b0, n_a, 1'b0);
        drive_stream(1'b1, n_b, 1'b0);
      join
    end
    while (ready_count <= index) @(posedge CLK);
    repeat (4) @(posedge CLK);
    check_value("ready pulses so far", 32'(ready_count), 32'(index + 1));
    check_value("elements not received", 32'(exp_data.size()), 32'd0);
  endtask

  ////////////////////////////////////////////////////////////
  // Output monitor sampled mid-cycle
  ////////////////////////////////////////////////////////////

  always @(negedge CLK) begin
    if (!RST) begin
      if (data_out_enable != '0) begin
        if (exp_data.size() == 0) begin
          other_error_count++;
          $display("Output strobe at %0t while no element was expected", $time);
        end else begin
          check_value("data_out", 32'(data_out), 32'(exp_data.pop_front()));
          check_value("data_out_enable", 32'(data_out_enable), 32'(exp_strobe.pop_front()));
        end
      end
      if (ready) begin
        ready_count++;
        check_value("elements left at ready", 32'(exp_data.size()), 32'd0);
        // Last element carries all three strobes
        check_value("strobe before ready", 32'(prev_enable), 32'b111);
      end
      prev_enable = data_out_enable;
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display(">>> FAIL");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    RST               = 1'b1;
    start             = 1'b0;
    modulo_in         = '0;
    size_a            = '0;
    size_b            = '0;
    data_a_in         = '0;
    data_a_enable     = 1'b0;
    data_b_in         = '0;
    data_b_enable     = 1'b0;
    prev_enable       = '0;
    ready_count       = 0;
    mismatch_count    = 0;
    other_error_count = 0;
    void'($urandom(SEED));
    // Shapes I, J, M, K then modulus, pattern, gap
    cases[0] = make_row(1, 1, 1, 1, 7, PAT_RANDOM, 1'b0);
    cases[1] = make_row(2, 3, 2, 2, 251, PAT_RANDOM, 1'b0);
    cases[2] = make_row(4, 4, 4, 4, 65521, PAT_RANDOM, 1'b0);
    cases[3] = make_row(3, 2, 4, 1, 1000, PAT_RANDOM, 1'b0);
    cases[4] = make_row(1, 4, 3, 4, 2, PAT_RANDOM, 1'b0);
    cases[5] = make_row(2, 2, 4, 3, 65535, PAT_MAX, 1'b0);
    cases[6] = make_row(4, 4, 4, 4, 65535, PAT_MAX, 1'b0);
    cases[7] = make_row(2, 3, 3, 2, 97, PAT_ZERO, 1'b0);
    cases[8] = make_row(3, 2, 3, 2, 12345, PAT_RANDOM, 1'b1);
    cases[9] = make_row(4, 4, 4, 4, 65534, PAT_RANDOM, 1'b1);
    repeat (16) @(posedge CLK);
    RST <= 1'b0;
    // Idle window where the monitor flags any stray output
    repeat (20) @(posedge CLK);
    check_value("ready pulses before start", 32'(ready_count), 32'd0);
    for (int c = 0; c < NUM_CASES; c++) begin
      run_case(c);
    end
    $display("Checks done: %0d mismatches, %0d other errors", mismatch_count, other_error_count);
    if (mismatch_count == 0 && other_error_count == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

/* verilog/ntm_scalar_adder.sv */
`timescale 1ns/1ps

module ntm_scalar_adder (
  input  logic                              CLK,
  input  logic                              RST,
  input  logic                              start,
  input  logic [ntm_tensor_pkg::DATA_W-1:0] modulo_in,
  input  logic [ntm_tensor_pkg::DATA_W-1:0] data_a_in,
  input  logic [ntm_tensor_pkg::DATA_W-1:0] data_b_in,
  output logic                              ready,
  output logic [ntm_tensor_pkg::DATA_W-1:0] data_out
);

  import ntm_tensor_pkg::*;

  // One extra bit for the carry
  logic [DATA_W:0] sum;
  logic [DATA_W:0] sum_red;

  assign sum = {1'b0, data_a_in} + {1'b0, data_b_in};
  // Both operands below modulus, one subtraction suffices
  assign sum_red = (sum >= {1'b0, modulo_in}) ? sum - {1'b0, modulo_in} : sum;

  // Done pulse one cycle after start
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      ready <= 1'b0;
    end else begin
      ready <= start;
    end
  end

  // Result held until the next start
  always_ff @(posedge CLK) begin
    if (start) begin
      data_out <= sum_red[DATA_W-1:0];
    end
  end

endmodule

/* verilog/ntm_scalar_multiplier.sv */
`timescale 1ns/1ps

module ntm_scalar_multiplier (
  input  logic                              CLK,
  input  logic                              RST,
  input  logic                              start,
  input  logic [ntm_tensor_pkg::DATA_W-1:0] modulo_in,
  input  logic [ntm_tensor_pkg::DATA_W-1:0] data_a_in,
  input  logic [ntm_tensor_pkg::DATA_W-1:0] data_b_in,
  output logic                              ready,
  output logic [ntm_tensor_pkg::DATA_W-1:0] data_out
);

  import ntm_tensor_pkg::*;

  // Control
  logic              busy;
  logic [STEP_W-1:0] step;

  // Operand and partial product registers
  logic [DATA_W-1:0] acc;
  logic [DATA_W-1:0] a_reg;
  logic [DATA_W-1:0] b_reg;
  logic [DATA_W-1:0] mod_reg;

  // One interleaved step
  logic [DATA_W:0]   dbl;
  logic [DATA_W:0]   dbl_red;
  logic [DATA_W:0]   sum;
  logic [DATA_W:0]   sum_red;
  logic [DATA_W-1:0] step_out;

  ////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////

  always_comb begin
    // Double, stays below twice the modulus
    dbl      = {acc, 1'b0};
    dbl_red  = (dbl >= {1'b0, mod_reg}) ? dbl - {1'b0, mod_reg} : dbl;
    // Add A when the current B bit is set
    sum      = dbl_red + {1'b0, a_reg};
    sum_red  = (sum >= {1'b0, mod_reg}) ? sum - {1'b0, mod_reg} : sum;
    step_out = b_reg[DATA_W-1] ? sum_red[DATA_W-1:0] : dbl_red[DATA_W-1:0];
  end

  assign data_out = acc;

  ////////////////////////////////////////////////////////////
  // Sequencing
  ////////////////////////////////////////////////////////////

  // DATA_W steps after the start edge, ready on the last
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy  <= 1'b0;
      step  <= '0;
      ready <= 1'b0;
    end else begin
      ready <= 1'b0;
      if (start) begin
        busy <= 1'b1;
        step <= '0;
      end else if (busy) begin
        step <= step + 1'b1;
        if (step == STEP_W'(DATA_W - 1)) begin
          busy  <= 1'b0;
          ready <= 1'b1;
        end
      end
    end
  end

  // Operands latched on start, B scanned from its MSB
  always_ff @(posedge CLK) begin
    if (start) begin
      acc     <= '0;
      a_reg   <= data_a_in;
      b_reg   <= data_b_in;
      mod_reg <= modulo_in;
    end else if (busy) begin
      acc   <= step_out;
      b_reg <= {b_reg[DATA_W-2:0], 1'b0};
    end
  end

endmodule

/* verilog/ntm_tensor_buffer.sv */
`timescale 1ns/1ps

module ntm_tensor_buffer (
  input  logic                              CLK,
  input  logic                              RST,
  input  logic                              clear,
  input  logic                              write_enable,
  input  ntm_tensor_pkg::tensor_dims_t      size,
  input  logic [ntm_tensor_pkg::DATA_W-1:0] data_in,
  input  logic [ntm_tensor_pkg::ADDR_W-1:0] read_addr,
  output logic [ntm_tensor_pkg::DATA_W-1:0] data_out,
  output logic                              full
);

  import ntm_tensor_pkg::*;

  // Storage for one tensor
  logic [DATA_W-1:0] mem [MAX_DIM*MAX_DIM*MAX_DIM];

  // Count reaches MAX_DIM cubed, so one bit wider than an address
  logic [ADDR_W:0] wr_count;
  logic [ADDR_W:0] total;

  // Element count from the sampled sizes
  assign total = (ADDR_W+1)'(size.i) * (ADDR_W+1)'(size.j) * (ADDR_W+1)'(size.k);

  // Combinational read port
  assign data_out = mem[read_addr];

  // Write pointer and loaded flag
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      wr_count <= '0;
      full     <= 1'b0;
    end else if (clear) begin
      wr_count <= '0;
      full     <= 1'b0;
    end else if (write_enable && !full) begin
      wr_count <= wr_count + 1'b1;
      // Last word of the tensor
      if (wr_count + 1'b1 == total) begin
        full <= 1'b1;
      end
    end
  end

  // Sequential fill, extra strobes dropped
  always_ff @(posedge CLK) begin
    if (write_enable && !full && !clear) begin
      mem[wr_count[ADDR_W-1:0]] <= data_in;
    end
  end

endmodule

/* verilog/ntm_tensor_pkg.sv */
package ntm_tensor_pkg;

  ////////////////////////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////////////////////////

  // Element and modulus width
  localparam int DATA_W = 16;

  // Largest extent of any tensor axis
  localparam int MAX_DIM = 4;

  // Axis size, holds 1 to MAX_DIM
  localparam int DIM_W = 3;

  // Axis index, holds 0 to MAX_DIM-1
  localparam int IDX_W = 2;

  // Buffer address, covers MAX_DIM cubed words
  localparam int ADDR_W = 6;

  // Step counter of the shift-add multiplier
  localparam int STEP_W = $clog2(DATA_W);

  ////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////

  // Sizes of one three-axis tensor
  typedef struct packed {
    logic [DIM_W-1:0] i;
    logic [DIM_W-1:0] j;
    logic [DIM_W-1:0] k;
  } tensor_dims_t;

  // Output boundary pulses, k every element
  typedef struct packed {
    logic i;
    logic j;
    logic k;
  } axis_strobe_t;

  // Controller sequence
  typedef enum logic [2:0] {
    STARTER,
    LOAD,
    FETCH,
    MULTIPLY,
    ACCUMULATE,
    EMIT,
    FINISH
  } ctrl_state_e;

endpackage

/* verilog/ntm_tensor_product.sv */
`timescale 1ns/1ps

module ntm_tensor_product (
  input  logic                              CLK,
  input  logic                              RST,
  input  logic                              start,
  input  logic [ntm_tensor_pkg::DATA_W-1:0] modulo_in,
  input  ntm_tensor_pkg::tensor_dims_t      size_a,
  input  ntm_tensor_pkg::tensor_dims_t      size_b,
  input  logic [ntm_tensor_pkg::DATA_W-1:0] data_a_in,
  input  logic                              data_a_enable,
  input  logic [ntm_tensor_pkg::DATA_W-1:0] data_b_in,
  input  logic                              data_b_enable,
  output logic                              ready,
  output logic [ntm_tensor_pkg::DATA_W-1:0] data_out,
  output ntm_tensor_pkg::axis_strobe_t      data_out_enable
);

  import ntm_tensor_pkg::*;

  ////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////

  ctrl_state_e state;

  // Sampled on start
  logic [DATA_W-1:0] mod_reg;
  tensor_dims_t      dims_a;
  tensor_dims_t      dims_b;

  // Loop indices, m is the contracted axis
  logic [IDX_W-1:0] i_cnt;
  logic [IDX_W-1:0] j_cnt;
  logic [IDX_W-1:0] k_cnt;
  logic [IDX_W-1:0] m_cnt;
  logic             i_last;
  logic             j_last;
  logic             k_last;
  logic             m_last;

  // Running sum of one output element
  logic [DATA_W-1:0] acc;

  // Buffers
  logic              clear_buffers;
  logic [ADDR_W-1:0] addr_a;
  logic [ADDR_W-1:0] addr_b;
  logic [DATA_W-1:0] data_a_buf;
  logic [DATA_W-1:0] data_b_buf;
  logic              full_a;
  logic              full_b;

  // Scalar units
  logic              start_scalar_multiplier;
  logic              ready_scalar_multiplier;
  logic [DATA_W-1:0] data_out_scalar_multiplier;
  logic              start_scalar_adder;
  logic              ready_scalar_adder;
  logic [DATA_W-1:0] data_out_scalar_adder;

  ////////////////////////////////////////////////////////////
  // Indexing
  ////////////////////////////////////////////////////////////

  // I = a.i, J = a.j, M = a.k = b.j, K = b.k
  assign i_last = DIM_W'(i_cnt) == dims_a.i - DIM_W'(1);
  assign j_last = DIM_W'(j_cnt) == dims_a.j - DIM_W'(1);
  assign m_last = DIM_W'(m_cnt) == dims_a.k - DIM_W'(1);
  assign k_last = DIM_W'(k_cnt) == dims_b.k - DIM_W'(1);

  // A[i][j][m] and B[i][m][k], row-major
  assign addr_a = (ADDR_W'(i_cnt) * ADDR_W'(dims_a.j) + ADDR_W'(j_cnt)) * ADDR_W'(dims_a.k)
                + ADDR_W'(m_cnt);
  assign addr_b = (ADDR_W'(i_cnt) * ADDR_W'(dims_b.j) + ADDR_W'(m_cnt)) * ADDR_W'(dims_b.k)
                + ADDR_W'(k_cnt);

  // Pulses derived from the state
  assign clear_buffers           = (state == STARTER) && start;
  assign start_scalar_multiplier = (state == FETCH);
  assign start_scalar_adder      = (state == MULTIPLY) && ready_scalar_multiplier;

  ////////////////////////////////////////////////////////////
  // Controller
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state           <= STARTER;
      ready           <= 1'b0;
      data_out        <= '0;
      data_out_enable <= '0;
      acc             <= '0;
      i_cnt           <= '0;
      j_cnt           <= '0;
      k_cnt           <= '0;
      m_cnt           <= '0;
    end else begin
      case (state)
        STARTER: begin
          ready <= 1'b0;
          if (start) begin
            acc   <= '0;
            i_cnt <= '0;
            j_cnt <= '0;
            k_cnt <= '0;
            m_cnt <= '0;
            state <= LOAD;
          end
        end
        // Both streams must be complete
        LOAD: begin
          if (full_a && full_b) begin
            state <= FETCH;
          end
        end
        // Operands read this cycle
        FETCH: begin
          state <= MULTIPLY;
        end
        MULTIPLY: begin
          if (ready_scalar_multiplier) begin
            state <= ACCUMULATE;
          end
        end
        ACCUMULATE: begin
          if (ready_scalar_adder) begin
            acc <= data_out_scalar_adder;
            if (m_last) begin
              // Present the element during EMIT
              m_cnt           <= '0;
              data_out        <= data_out_scalar_adder;
              data_out_enable <= '{i: k_last && j_last, j: k_last, k: 1'b1};
              state           <= EMIT;
            end else begin
              m_cnt <= m_cnt + 1'b1;
              state <= FETCH;
            end
          end
        end
        EMIT: begin
          data_out_enable <= '0;
          acc             <= '0;
          // Advance k, then j, then i
          if (k_last) begin
            k_cnt <= '0;
            if (j_last) begin
              j_cnt <= '0;
              i_cnt <= i_cnt + 1'b1;
            end else begin
              j_cnt <= j_cnt + 1'b1;
            end
          end else begin
            k_cnt <= k_cnt + 1'b1;
          end
          if (i_last && j_last && k_last) begin
            ready <= 1'b1;
            state <= FINISH;
          end else begin
            state <= FETCH;
          end
        end
        FINISH: begin
          ready <= 1'b0;
          state <= STARTER;
        end
        default: begin
          state <= STARTER;
        end
      endcase
    end
  end

  // Sizes and modulus for the whole case
  always_ff @(posedge CLK) begin
    if (clear_buffers) begin
      mod_reg <= modulo_in;
      dims_a  <= size_a;
      dims_b  <= size_b;
    end
  end

  ////////////////////////////////////////////////////////////
  // Instances
  ////////////////////////////////////////////////////////////

  ntm_tensor_buffer u_buffer_a (
    .CLK          (CLK),
    .RST          (RST),
    .clear        (clear_buffers),
    .write_enable (data_a_enable),
    .size         (dims_a),
    .data_in      (data_a_in),
    .read_addr    (addr_a),
    .data_out     (data_a_buf),
    .full         (full_a)
  );

  ntm_tensor_buffer u_buffer_b (
    .CLK          (CLK),
    .RST          (RST),
    .clear        (clear_buffers),
    .write_enable (data_b_enable),
    .size         (dims_b),
    .data_in      (data_b_in),
    .read_addr    (addr_b),
    .data_out     (data_b_buf),
    .full         (full_b)
  );

  // Product A[i][j][m] * B[i][m][k]
  ntm_scalar_multiplier u_scalar_multiplier (
    .CLK       (CLK),
    .RST       (RST),
    .start     (start_scalar_multiplier),
    .modulo_in (mod_reg),
    .data_a_in (data_a_buf),
    .data_b_in (data_b_buf),
    .ready     (ready_scalar_multiplier),
    .data_out  (data_out_scalar_multiplier)
  );

  // Running sum over m
  ntm_scalar_adder u_scalar_adder (
    .CLK       (CLK),
    .RST       (RST),
    .start     (start_scalar_adder),
    .modulo_in (mod_reg),
    .data_a_in (acc),
    .data_b_in (data_out_scalar_multiplier),
    .ready     (ready_scalar_adder),
    .data_out  (data_out_scalar_adder)
  );

endmodule
